/* design/sfp_link_pkg.sv */
// GMII framing constants and byte type shared by the SFP loopback datapath blocks
`default_nettype none

package sfp_link_pkg;

    // One GMII data byte
    typedef logic [7:0] gmii_byte_t;

    // Preamble filler and start-of-frame delimiter
    localparam gmii_byte_t GMII_PREAMBLE = 8'h55;
    localparam gmii_byte_t GMII_SFD      = 8'hD5;

    // Preamble bytes emitted ahead of the SFD on transmit
    localparam int PREAMBLE_LEN = 7;

    // Minimum idle cycles between transmitted frames
    localparam int IFG_LEN = 12;

endpackage

`default_nettype wire

/* design/sfp_status_sync.sv */
// Flop-chain synchronizer that brings the SFP status pins into the 125 MHz core domain
`timescale 1ns/10ps
`default_nettype none

module sfp_status_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic       clk_125mhz_int,
    input  logic       rst_n_i,
    input  logic [2:0] async_i,
    output logic [2:0] sync_o
);

    logic [2:0] sync_q [SYNC_STAGES];

    // Reset level reads as fault, loss and absent so the link starts down
    always_ff @(posedge clk_125mhz_int or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= 3'b111;
            end
        end else begin
            sync_q[0] <= async_i;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign sync_o = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

/* design/gmii_rx_framer.sv */
// GMII receive framer that strips preamble and SFD and flags frame end and receive errors
`timescale 1ns/10ps
`default_nettype none

module gmii_rx_framer import sfp_link_pkg::*; (
    input  logic       clk_125mhz_int,
    input  logic       rst_n_i,
    input  gmii_byte_t gmii_rxd_i,
    input  logic       gmii_rx_dv_i,
    input  logic       gmii_rx_er_i,
    input  logic       fwd_en_i,
    output gmii_byte_t rx_byte_o,
    output logic       rx_valid_o,
    output logic       rx_last_o,
    output logic       rx_bad_o
);

    typedef enum logic [1:0] {
        IDLE,
        PREAMBLE,
        DATA,
        DISCARD
    } rx_state_e;

    rx_state_e state_q;
    logic      err_q;

    always_ff @(posedge clk_125mhz_int or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            err_q      <= 1'b0;
            rx_valid_o <= 1'b0;
            rx_last_o  <= 1'b0;
            rx_bad_o   <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            rx_last_o  <= 1'b0;
            rx_bad_o   <= 1'b0;
            case (state_q)
                IDLE, PREAMBLE: begin
                    if (!gmii_rx_dv_i) begin
                        state_q <= IDLE;
                    end else if (gmii_rx_er_i) begin
                        state_q <= DISCARD;
                    end else if (gmii_rxd_i == GMII_SFD) begin
                        // Link must be up at the SFD or the whole frame is skipped
                        state_q <= fwd_en_i ? DATA : DISCARD;
                        err_q   <= 1'b0;
                    end else if (gmii_rxd_i == GMII_PREAMBLE) begin
                        state_q <= PREAMBLE;
                    end else begin
                        state_q <= DISCARD;
                    end
                end
                DATA: begin
                    if (gmii_rx_dv_i) begin
                        rx_valid_o <= 1'b1;
                        err_q      <= err_q | gmii_rx_er_i;
                    end else begin
                        // End marker follows the last byte by one cycle
                        rx_last_o <= 1'b1;
                        rx_bad_o  <= err_q;
                        state_q   <= IDLE;
                    end
                end
                DISCARD: begin
                    if (!gmii_rx_dv_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Data byte lags the GMII bus by exactly one cycle
    always_ff @(posedge clk_125mhz_int) begin
        rx_byte_o <= gmii_rxd_i;
    end

endmodule

`default_nettype wire

/* design/frame_buffer.sv */
// Store-and-forward frame buffer with per-frame commit or rollback and credit-gated readout
`timescale 1ns/10ps
`default_nettype none

module frame_buffer import sfp_link_pkg::*; #(
    parameter int BUF_ADDR_W = 9,
    parameter int CREDITS    = 4
) (
    input  logic       clk_125mhz_int,
    input  logic       rst_n_i,
    input  gmii_byte_t rx_byte_i,
    input  logic       rx_valid_i,
    input  logic       rx_last_i,
    input  logic       rx_bad_i,
    input  logic       credit_i,
    output gmii_byte_t tx_byte_o,
    output logic       tx_valid_o,
    output logic       tx_last_o
);

    localparam int DEPTH = 2 ** BUF_ADDR_W;
    localparam int FRM_W = BUF_ADDR_W + 1;
    localparam int CRD_W = $clog2(CREDITS + 1);

    // Entry is {end of frame, data}
    logic [8:0] mem [DEPTH];

    logic [BUF_ADDR_W-1:0] wr_spec_q;
    logic [BUF_ADDR_W-1:0] wr_commit_q;
    logic [BUF_ADDR_W-1:0] rd_ptr_q;
    logic [FRM_W-1:0]      frames_q;
    logic [CRD_W-1:0]      credits_q;
    gmii_byte_t            pend_byte_q;
    logic                  pend_vld_q;
    logic                  ovf_q;

    logic [BUF_ADDR_W-1:0] wr_next;
    logic                  wr_full;
    logic                  wr_en;
    logic [8:0]            wr_data;
    logic                  commit;
    logic                  rollback;
    logic                  send;
    logic                  send_eof;

    // One byte is held back so the end flag can go in with the final byte
    always_comb begin
        wr_next  = wr_spec_q + BUF_ADDR_W'(1);
        wr_full  = (wr_next == rd_ptr_q);
        wr_en    = rx_valid_i && pend_vld_q && !ovf_q && !wr_full;
        wr_data  = {1'b0, pend_byte_q};
        commit   = 1'b0;
        rollback = 1'b0;
        if (rx_last_i) begin
            if (rx_bad_i || ovf_q || !pend_vld_q || wr_full) begin
                rollback = 1'b1;
            end else begin
                wr_en      = 1'b1;
                wr_data[8] = 1'b1;
                commit     = 1'b1;
            end
        end
    end

    // Only whole committed frames are read, one byte per credit
    assign send     = (frames_q != '0) && (credits_q != '0);
    assign send_eof = send && mem[rd_ptr_q][8];

    always_ff @(posedge clk_125mhz_int or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_spec_q   <= '0;
            wr_commit_q <= '0;
            rd_ptr_q    <= '0;
            frames_q    <= '0;
            credits_q   <= CRD_W'(CREDITS);
            pend_vld_q  <= 1'b0;
            ovf_q       <= 1'b0;
            tx_valid_o  <= 1'b0;
        end else begin
            if (rx_valid_i) begin
                pend_vld_q <= 1'b1;
            end
            if (rx_valid_i && pend_vld_q && wr_full) begin
                ovf_q <= 1'b1;
            end
            if (wr_en) begin
                wr_spec_q <= wr_next;
            end
            if (commit) begin
                wr_commit_q <= wr_next;
            end
            if (rollback) begin
                wr_spec_q <= wr_commit_q;
            end
            if (rx_last_i) begin
                pend_vld_q <= 1'b0;
                ovf_q      <= 1'b0;
            end
            if (send) begin
                rd_ptr_q <= rd_ptr_q + BUF_ADDR_W'(1);
            end
            frames_q   <= frames_q + FRM_W'(commit) - FRM_W'(send_eof);
            credits_q  <= credits_q + CRD_W'(credit_i) - CRD_W'(send);
            tx_valid_o <= send;
        end
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (wr_en) begin
            mem[wr_spec_q] <= wr_data;
        end
        if (rx_valid_i) begin
            pend_byte_q <= rx_byte_i;
        end
        if (send) begin
            {tx_last_o, tx_byte_o} <= mem[rd_ptr_q];
        end
    end

endmodule

`default_nettype wire

/* design/gmii_tx_framer.sv */
// GMII transmit framer with a credit-fed staging queue, preamble, SFD and inter-frame gap
`timescale 1ns/10ps
`default_nettype none

module gmii_tx_framer import sfp_link_pkg::*; #(
    parameter int CREDITS = 4
) (
    input  logic       clk_125mhz_int,
    input  logic       rst_n_i,
    input  gmii_byte_t tx_byte_i,
    input  logic       tx_valid_i,
    input  logic       tx_last_i,
    output logic       credit_o,
    output gmii_byte_t gmii_txd_o,
    output logic       gmii_tx_en_o,
    output logic       gmii_tx_er_o,
    output logic       frame_sent_o
);

    localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CNT_W = $clog2(CREDITS + 1);
    localparam int TMR_W = $clog2(IFG_LEN + 1);

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        SFD,
        DATA,
        GAP
    } tx_state_e;

    tx_state_e        state_q;
    logic [8:0]       stage_q [CREDITS];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] lasts_q;
    logic [TMR_W-1:0] timer_q;

    logic head_last;
    logic pop;
    logic start;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(CREDITS - 1)) begin
            return '0;
        end
        return p + PTR_W'(1);
    endfunction

    assign head_last = stage_q[head_q][8];
    assign pop       = (state_q == DATA) && (count_q != '0);
    // Full queue or a whole short frame keeps the payload from starving
    assign start     = (count_q == CNT_W'(CREDITS)) || (lasts_q != '0);

    // Each popped byte frees one staging slot
    assign credit_o     = pop;
    assign gmii_tx_er_o = 1'b0;

    always_ff @(posedge clk_125mhz_int or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= IDLE;
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            lasts_q      <= '0;
            timer_q      <= '0;
            gmii_tx_en_o <= 1'b0;
            frame_sent_o <= 1'b0;
        end else begin
            if (tx_valid_i) begin
                tail_q <= ptr_inc(tail_q);
            end
            if (pop) begin
                head_q <= ptr_inc(head_q);
            end
            count_q <= count_q + CNT_W'(tx_valid_i) - CNT_W'(pop);
            lasts_q <= lasts_q + CNT_W'(tx_valid_i && tx_last_i) - CNT_W'(pop && head_last);

            gmii_tx_en_o <= (state_q == PREAMBLE) || (state_q == SFD) || pop;
            frame_sent_o <= pop && head_last;

            case (state_q)
                IDLE: begin
                    timer_q <= '0;
                    if (start) begin
                        state_q <= PREAMBLE;
                    end
                end
                PREAMBLE: begin
                    if (timer_q == TMR_W'(PREAMBLE_LEN - 1)) begin
                        state_q <= SFD;
                        timer_q <= '0;
                    end else begin
                        timer_q <= timer_q + TMR_W'(1);
                    end
                end
                SFD: state_q <= DATA;
                DATA: begin
                    if (pop && head_last) begin
                        state_q <= GAP;
                    end
                end
                GAP: begin
                    if (timer_q == TMR_W'(IFG_LEN - 1)) begin
                        state_q <= IDLE;
                    end else begin
                        timer_q <= timer_q + TMR_W'(1);
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_125mhz_int) begin
        if (tx_valid_i) begin
            stage_q[tail_q] <= {tx_last_i, tx_byte_i};
        end
        case (state_q)
            PREAMBLE: gmii_txd_o <= GMII_PREAMBLE;
            SFD:      gmii_txd_o <= GMII_SFD;
            DATA:     gmii_txd_o <= stage_q[head_q][7:0];
            default:  gmii_txd_o <= 8'h00;
        endcase
    end

endmodule

`default_nettype wire

/* design/sfp_link_ctrl.sv */
// SFP link state machine gating forwarding, driving tx_disable and the status LEDs
`timescale 1ns/10ps
`default_nettype none

module sfp_link_ctrl #(
    parameter int LINK_HOLD = 64
) (
    input  logic       clk_125mhz_int,
    input  logic       rst_n_i,
    input  logic [2:0] status_i,
    input  logic       frame_sent_i,
    output logic       fwd_en_o,
    output logic       sfp_tx_disable_o,
    output logic [1:0] led_o
);

    localparam int HOLD_W = $clog2(LINK_HOLD + 1);

    typedef enum logic [1:0] {
        DOWN,
        SETTLE,
        UP
    } link_state_e;

    link_state_e       state_q;
    logic [HOLD_W-1:0] hold_q;
    logic              act_q;
    logic              fault;
    logic              los;
    logic              absent;
    logic              clean;

    assign {fault, los, absent} = status_i;
    assign clean = !(fault || los || absent);

    always_ff @(posedge clk_125mhz_int or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q          <= DOWN;
            hold_q           <= '0;
            act_q            <= 1'b0;
            sfp_tx_disable_o <= 1'b1;
        end else begin
            // Laser stays off without a module or with a reported fault
            sfp_tx_disable_o <= fault || absent;
            if (frame_sent_i) begin
                act_q <= !act_q;
            end
            case (state_q)
                DOWN: begin
                    if (clean) begin
                        state_q <= SETTLE;
                        hold_q  <= HOLD_W'(1);
                    end
                end
                SETTLE: begin
                    if (!clean) begin
                        state_q <= DOWN;
                    end else if (hold_q >= HOLD_W'(LINK_HOLD - 1)) begin
                        state_q <= UP;
                    end else begin
                        hold_q <= hold_q + HOLD_W'(1);
                    end
                end
                UP: begin
                    if (!clean) begin
                        state_q <= DOWN;
                    end
                end
                default: state_q <= DOWN;
            endcase
        end
    end

    // Drops in the same cycle a status pin goes bad
    assign fwd_en_o = (state_q == UP) && clean;
    assign led_o    = {act_q, state_q == UP};

endmodule

`default_nettype wire

/* design/sfp_loopback_core.sv */
// Core top level of the SFP GMII store-and-forward loopback, fed by the board-level clocking
`timescale 1ns/10ps
`default_nettype none

module sfp_loopback_core import sfp_link_pkg::*; #(
    parameter int BUF_ADDR_W  = 9,
    parameter int CREDITS     = 4,
    parameter int LINK_HOLD   = 64,
    parameter int SYNC_STAGES = 2
) (
    input  logic       clk_125mhz_int,
    input  logic       rst_n_i,
    input  gmii_byte_t gmii_rxd_i,
    input  logic       gmii_rx_dv_i,
    input  logic       gmii_rx_er_i,
    input  logic       sfp_tx_fault_i,
    input  logic       sfp_rx_los_i,
    input  logic       sfp_mod_abs_i,
    output gmii_byte_t gmii_txd_o,
    output logic       gmii_tx_en_o,
    output logic       gmii_tx_er_o,
    output logic       sfp_tx_disable_o,
    output logic [1:0] led_o
);

    logic [2:0] status_sync;
    logic       fwd_en;
    gmii_byte_t rx_byte;
    logic       rx_valid;
    logic       rx_last;
    logic       rx_bad;
    gmii_byte_t tx_byte;
    logic       tx_valid;
    logic       tx_last;
    logic       credit;
    logic       frame_sent;

    // Status order is {fault, los, absent}
    sfp_status_sync #(
        .SYNC_STAGES(SYNC_STAGES)
    ) u_status_sync (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_n_i       (rst_n_i),
        .async_i       ({sfp_tx_fault_i, sfp_rx_los_i, sfp_mod_abs_i}),
        .sync_o        (status_sync)
    );

    sfp_link_ctrl #(
        .LINK_HOLD(LINK_HOLD)
    ) u_link_ctrl (
        .clk_125mhz_int  (clk_125mhz_int),
        .rst_n_i         (rst_n_i),
        .status_i        (status_sync),
        .frame_sent_i    (frame_sent),
        .fwd_en_o        (fwd_en),
        .sfp_tx_disable_o(sfp_tx_disable_o),
        .led_o           (led_o)
    );

    gmii_rx_framer u_rx_framer (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_n_i       (rst_n_i),
        .gmii_rxd_i    (gmii_rxd_i),
        .gmii_rx_dv_i  (gmii_rx_dv_i),
        .gmii_rx_er_i  (gmii_rx_er_i),
        .fwd_en_i      (fwd_en),
        .rx_byte_o     (rx_byte),
        .rx_valid_o    (rx_valid),
        .rx_last_o     (rx_last),
        .rx_bad_o      (rx_bad)
    );

    frame_buffer #(
        .BUF_ADDR_W(BUF_ADDR_W),
        .CREDITS   (CREDITS)
    ) u_frame_buffer (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_n_i       (rst_n_i),
        .rx_byte_i     (rx_byte),
        .rx_valid_i    (rx_valid),
        .rx_last_i     (rx_last),
        .rx_bad_i      (rx_bad),
        .credit_i      (credit),
        .tx_byte_o     (tx_byte),
        .tx_valid_o    (tx_valid),
        .tx_last_o     (tx_last)
    );

    gmii_tx_framer #(
        .CREDITS(CREDITS)
    ) u_tx_framer (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_n_i       (rst_n_i),
        .tx_byte_i     (tx_byte),
        .tx_valid_i    (tx_valid),
        .tx_last_i     (tx_last),
        .credit_o      (credit),
        .gmii_txd_o    (gmii_txd_o),
        .gmii_tx_en_o  (gmii_tx_en_o),
        .gmii_tx_er_o  (gmii_tx_er_o),
        .frame_sent_o  (frame_sent)
    );

endmodule

`default_nettype wire

/* sim/tb_sfp_loopback.sv */
// Testbench for the SFP GMII loopback core that runs from the file list under Verilator --binary --timing
`timescale 1ns/10ps
`default_nettype none

module tb_sfp_loopback import sfp_link_pkg::*; ();

    localparam int LINK_HOLD   = 64;
    localparam int SYNC_STAGES = 2;
    // About twice the 20 frames, idle waits and two link settles
    localparam int TIMEOUT_CYCLES = 4000;

    logic       clk_125mhz_int;
    logic       rst_n_i;
    gmii_byte_t gmii_rxd_i;
    logic       gmii_rx_dv_i;
    logic       gmii_rx_er_i;
    logic       sfp_tx_fault_i;
    logic       sfp_rx_los_i;
    logic       sfp_mod_abs_i;
    gmii_byte_t gmii_txd_o;
    logic       gmii_tx_en_o;
    logic       gmii_tx_er_o;
    logic       sfp_tx_disable_o;
    logic [1:0] led_o;

    logic [7:0] pay [64];
    logic [7:0] exp_bytes [$];
    int         exp_lens [$];
    logic [7:0] wire_q [$];
    int         err_count = 0;
    int         test_errs = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    int         cycles = 0;
    int         idle_cnt = 0;
    bit         seen_frame = 1'b0;
    bit         act_exp = 1'b0;
    int         wait_cycles;

    sfp_loopback_core #(
        .LINK_HOLD  (LINK_HOLD),
        .SYNC_STAGES(SYNC_STAGES)
    ) uut (
        .clk_125mhz_int  (clk_125mhz_int),
        .rst_n_i         (rst_n_i),
        .gmii_rxd_i      (gmii_rxd_i),
        .gmii_rx_dv_i    (gmii_rx_dv_i),
        .gmii_rx_er_i    (gmii_rx_er_i),
        .sfp_tx_fault_i  (sfp_tx_fault_i),
        .sfp_rx_los_i    (sfp_rx_los_i),
        .sfp_mod_abs_i   (sfp_mod_abs_i),
        .gmii_txd_o      (gmii_txd_o),
        .gmii_tx_en_o    (gmii_tx_en_o),
        .gmii_tx_er_o    (gmii_tx_er_o),
        .sfp_tx_disable_o(sfp_tx_disable_o),
        .led_o           (led_o)
    );

    initial clk_125mhz_int = 1'b0;
    always #4 clk_125mhz_int = ~clk_125mhz_int;

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED at %0t: %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
            err_count++;
        end
    endtask

    // Expected wire image is preamble, SFD, then the payload as received
    function automatic void build_expected(input int len);
        for (int i = 0; i < PREAMBLE_LEN; i++) begin
            exp_bytes.push_back(8'h55);
        end
        exp_bytes.push_back(8'hD5);
        for (int i = 0; i < len; i++) begin
            exp_bytes.push_back(pay[i]);
        end
        exp_lens.push_back(PREAMBLE_LEN + 1 + len);
    endfunction

    function automatic int rand_len();
        return 20 + int'($urandom % 41);
    endfunction

    // err_at is the payload index of the error or negative for a clean frame
    task automatic send_frame(input int len, input bit accept, input int err_at);
        for (int i = 0; i < len; i++) begin
            pay[i] = 8'($urandom);
        end
        if (accept) begin
            build_expected(len);
        end
        for (int i = 0; i < PREAMBLE_LEN + 1 + len; i++) begin
            @(negedge clk_125mhz_int);
            gmii_rx_dv_i = 1'b1;
            gmii_rx_er_i = (err_at >= 0) && (i == PREAMBLE_LEN + 1 + err_at);
            if (i < PREAMBLE_LEN) begin
                gmii_rxd_i = 8'h55;
            end else if (i == PREAMBLE_LEN) begin
                gmii_rxd_i = 8'hD5;
            end else begin
                gmii_rxd_i = pay[i - PREAMBLE_LEN - 1];
            end
        end
        @(negedge clk_125mhz_int);
        gmii_rx_dv_i = 1'b0;
        gmii_rx_er_i = 1'b0;
        gmii_rxd_i   = 8'h00;
        repeat (IFG_LEN - 1) @(negedge clk_125mhz_int);
    endtask

    task automatic wait_drain();
        while (exp_lens.size() != 0) begin
            @(negedge clk_125mhz_int);
        end
        repeat (IFG_LEN + 4) @(negedge clk_125mhz_int);
    endtask

    task automatic wait_led0(input logic level, input int limit, output int n);
        n = 0;
        while (led_o[0] !== level && n < limit) begin
            @(negedge clk_125mhz_int);
            n++;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        if (err_count == test_errs) begin
            $display("test %0d %s: PASS", num, name);
            tests_passed++;
        end else begin
            $display("test %0d %s: FAIL (%0d errors)", num, name, err_count - test_errs);
            tests_failed++;
        end
        test_errs = err_count;
    endtask

    task automatic compare_frame();
        int         n;
        logic [7:0] e;
        if (exp_lens.size() == 0) begin
            $display("ERROR at %0t: unexpected frame of %0d bytes on the GMII transmit side",
                     $time, wire_q.size());
            err_count++;
        end else begin
            n = exp_lens.pop_front();
            check_val("frame length", 32'(n), 32'(wire_q.size()));
            for (int i = 0; i < n; i++) begin
                e = exp_bytes.pop_front();
                if (i < wire_q.size()) begin
                    check_val("gmii_txd_o", 32'(e), 32'(wire_q[i]));
                end
            end
        end
    endtask

    // Transmit monitor sampling away from the active clock edge
    always @(negedge clk_125mhz_int) begin
        if (rst_n_i) begin
            check_val("gmii_tx_er_o", 32'd0, 32'(gmii_tx_er_o));
            if (gmii_tx_en_o) begin
                if (wire_q.size() == 0 && seen_frame && idle_cnt < IFG_LEN) begin
                    $display("ERROR at %0t: transmit gap of %0d cycles is shorter than %0d",
                             $time, idle_cnt, IFG_LEN);
                    err_count++;
                end
                wire_q.push_back(gmii_txd_o);
                idle_cnt = 0;
            end else begin
                idle_cnt++;
                if (wire_q.size() != 0) begin
                    compare_frame();
                    seen_frame = 1'b1;
                    act_exp    = ~act_exp;
                    check_val("led_o[1]", 32'(act_exp), 32'(led_o[1]));
                    wire_q.delete();
                end
            end
        end
    end

    always @(posedge clk_125mhz_int) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(48));
        rst_n_i        = 1'b0;
        gmii_rxd_i     = 8'h00;
        gmii_rx_dv_i   = 1'b0;
        gmii_rx_er_i   = 1'b0;
        sfp_tx_fault_i = 1'b1;
        sfp_rx_los_i   = 1'b1;
        sfp_mod_abs_i  = 1'b1;
        repeat (10) @(negedge clk_125mhz_int);
        rst_n_i = 1'b1;

        // Link is down so this frame must not come out
        @(negedge clk_125mhz_int);
        check_val("sfp_tx_disable_o", 32'd1, 32'(sfp_tx_disable_o));
        check_val("led_o", 32'd0, 32'(led_o));
        send_frame(rand_len(), 1'b0, -1);
        repeat (150) @(negedge clk_125mhz_int);
        sfp_tx_fault_i = 1'b0;
        sfp_rx_los_i   = 1'b0;
        sfp_mod_abs_i  = 1'b0;
        wait_led0(1'b1, LINK_HOLD + SYNC_STAGES + 8, wait_cycles);
        check_val("led_o[0]", 32'd1, 32'(led_o[0]));
        if (wait_cycles < LINK_HOLD) begin
            $display("ERROR at %0t: link came up after only %0d cycles", $time, wait_cycles);
            err_count++;
        end
        check_val("sfp_tx_disable_o", 32'd0, 32'(sfp_tx_disable_o));
        finish_test(1, "reset and status");

        for (int f = 0; f < 10; f++) begin
            send_frame(rand_len(), 1'b1, -1);
        end
        wait_drain();
        finish_test(2, "loopback");

        send_frame(rand_len(), 1'b1, -1);
        send_frame(40, 1'b0, 17);
        send_frame(rand_len(), 1'b1, -1);
        wait_drain();
        finish_test(3, "error drop");

        // Short frames keep the transmitter busy back to back
        for (int f = 0; f < 3; f++) begin
            send_frame(20, 1'b1, -1);
        end
        wait_drain();
        finish_test(4, "gap and activity");

        sfp_rx_los_i = 1'b1;
        wait_led0(1'b0, SYNC_STAGES + 4, wait_cycles);
        check_val("led_o[0]", 32'd0, 32'(led_o[0]));
        check_val("sfp_tx_disable_o", 32'd0, 32'(sfp_tx_disable_o));
        send_frame(rand_len(), 1'b0, -1);
        repeat (150) @(negedge clk_125mhz_int);
        sfp_rx_los_i = 1'b0;
        wait_led0(1'b1, LINK_HOLD + SYNC_STAGES + 8, wait_cycles);
        check_val("led_o[0]", 32'd1, 32'(led_o[0]));
        send_frame(rand_len(), 1'b1, -1);
        send_frame(rand_len(), 1'b1, -1);
        wait_drain();
        finish_test(5, "link loss");

        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
design/sfp_link_pkg.sv
design/sfp_status_sync.sv
design/gmii_rx_framer.sv
design/frame_buffer.sv
design/gmii_tx_framer.sv
design/sfp_link_ctrl.sv
design/sfp_loopback_core.sv
sim/tb_sfp_loopback.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SFP loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_sfp_loopback -o tb_sfp_loopback
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_sfp_loopback)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TESTS PASSED"; then
    exit 0
fi

echo "Pass line not found in simulation output"
exit 1
